/* dnaMatcher.f */
common/dnaPkg.sv
matcher/patternStore.sv
matcher/classMembers.sv
matcher/matchControl.sv
hw/dnaMatcher.sv
test/dnaMatcherTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module dnaMatcherTb -f dnaMatcher.f -o dnaMatcherSim

output=$(./obj_dir/dnaMatcherSim)
echo "$output"

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

/* test/dnaMatcherTb.sv */
module dnaMatcherTb;
    timeunit 1ns;
    timeprecision 1ps;
    import dnaPkg::*;

    localparam int NumCases = 200;

    logic                clock;
    logic                reset_N;
    logic                patWrValid;
    logic                patWrReady;
    logic [PatAddrW-1:0] patWrAddr;
    opT                  patWrOp;
    baseT                patWrBase;
    logic                seqWrValid;
    logic                seqWrReady;
    logic [SeqAddrW-1:0] seqWrAddr;
    baseT                seqWrBase;
    logic                startValid;
    logic                startReady;
    logic [SeqLenW-1:0]  startLen;
    logic                resultValid;
    logic                resultReady;
    resultT              result;

    opT          patOp   [PatDepth];   // Mirror of the DUT memories
    baseT        patBase [PatDepth];
    baseT        seqMem  [SeqDepth];
    logic [31:0] lfsr = 32'h219a;
    int          errors = 0;

    dnaMatcher i_dut (.*);

    always #5 clock = ~clock;

    // Galois LFSR, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic baseT randBase();
        logic [31:0] r;
        r = randBits(2);
        return baseT'({1'b0, r[1:0]});
    endfunction

    function automatic logic isAcgt(input baseT b);
        logic [2:0] code;
        code = b;
        return code[2] == 1'b0;   // Codes 0 to 3
    endfunction

    // Walks the pattern the way the controller is specified to
    function automatic resultT predictResult(input int len);
        int         p, s, k, i;
        logic [3:0] seen;
        logic [2:0] code;
        logic       fault, done;
        resultT     res;
        p = 0;
        s = 0;
        done = 1'b0;
        res = resError;
        while (!done) begin
            done = 1'b1;
            if (p >= PatDepth) begin
                res = resError;
            end else if (patOp[p] == opMember) begin
                res = (patBase[p] == nucOther) ? resFound : resError;
            end else if (patOp[p] == opLiteral) begin
                if (!isAcgt(patBase[p])) res = resError;
                else if (s == len || patBase[p] != seqMem[s]) res = resNoMatch;
                else begin
                    p++;
                    s++;
                    done = 1'b0;
                end
            end else begin
                k = (patOp[p] == opClass3) ? 3 : 2;
                seen = '0;
                fault = 1'b0;
                for (i = 0; i < k && !fault; i++) begin
                    if (p >= PatDepth || (i > 0 && patOp[p] != opMember)) begin
                        fault = 1'b1;
                    end else begin
                        code = patBase[p];
                        if (!isAcgt(patBase[p]) || seen[code[1:0]]) fault = 1'b1;
                        else seen[code[1:0]] = 1'b1;
                        p++;
                    end
                end
                code = (s < SeqDepth) ? seqMem[s] : nucA;
                if (fault) res = resError;
                else if (s == len || !isAcgt(baseT'(code))) res = resNoMatch;
                else if (!seen[code[1:0]]) res = resNoMatch;
                else begin
                    s++;
                    done = 1'b0;
                end
            end
        end
        return res;
    endfunction

    task automatic expectFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Write tasks start and end just after a falling edge
    task automatic writePattern(input int addr, input opT op, input baseT b);
        int waited;
        waited = 0;
        patOp[addr] = op;
        patBase[addr] = b;
        patWrValid = 1'b1;
        patWrAddr = addr[PatAddrW-1:0];
        patWrOp = op;
        patWrBase = b;
        while (!patWrReady && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        if (!patWrReady) begin
            errors++;
            $display("Pattern write to entry %0d was never accepted", addr);
        end
        @(negedge clock);
        patWrValid = 1'b0;
    endtask

    task automatic writeSequence(input int addr, input baseT b);
        int waited;
        waited = 0;
        seqWrValid = 1'b1;
        seqWrAddr = addr[SeqAddrW-1:0];
        seqWrBase = b;
        while (!seqWrReady && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        if (!seqWrReady) begin
            errors++;
            $display("Sequence write to base %0d was never accepted", addr);
        end
        @(negedge clock);
        seqWrValid = 1'b0;
    endtask

    // Random pattern, a sequence that satisfies it, then optional damage
    task automatic buildCase(output int patCount, output int len);
        int          p, s, e, i, k, nElem;
        logic [31:0] r, r2;
        logic [1:0]  x, step;
        baseT        m [3];
        p = 0;
        s = 0;
        r = randBits(3);
        nElem = (r[2:0] == 3'd7) ? 6 : int'(r[2:0]);
        for (e = 0; e < nElem && p <= 12; e++) begin
            r = randBits(6);   // Kind, fault select, member pick
            if (r[1] == 1'b0) begin
                m[0] = randBase();
                patOp[p] = opLiteral;
                patBase[p] = m[0];
                if (r[4:2] == 3'd0 && r[0]) patOp[p] = opMember;   // Stray head
                else if (r[4:2] == 3'd0) patBase[p] = nucOther;
                seqMem[s] = m[0];
                p++;
            end else begin
                k = r[0] ? 3 : 2;
                r2 = randBits(5);
                x = r2[1:0];
                step = r2[2] ? 2'd1 : 2'd3;
                for (i = 0; i < 3; i++) begin
                    m[i] = baseT'({1'b0, x});
                    x = x + step;
                end
                if (r[4:2] == 3'd0 && r2[3]) m[k-1] = m[0];   // Duplicate member
                else if (r[4:2] == 3'd0 && r2[4]) m[1] = nucOther;
                else if (r[4:2] == 3'd0) m[0] = nucOther;
                patOp[p] = (k == 3) ? opClass3 : opClass2;
                patBase[p] = m[0];
                for (i = 1; i < k; i++) begin
                    patOp[p + i] = opMember;
                    patBase[p + i] = m[i];
                end
                seqMem[s] = r[5] ? m[1] : m[0];
                p = p + k;
            end
            s++;
        end
        r = randBits(5);
        if (r[3:0] != 4'd0) begin
            patOp[p] = opMember;   // End marker
            patBase[p] = nucOther;
            p++;
        end else if (r[4]) begin
            while (p < PatDepth) begin   // Literals all the way, no end marker
                m[0] = randBase();
                patOp[p] = opLiteral;
                patBase[p] = m[0];
                seqMem[s] = m[0];
                p++;
                s++;
            end
        end
        for (i = s; i < SeqDepth; i++) seqMem[i] = randBase();
        r = randBits(6);
        if (r[5]) seqMem[r[4:0]] = randBase();
        r = randBits(7);
        if (r[6]) len = int'(r[5:0]) % 33;
        else len = s + int'(r[1:0]);
        if (len > SeqDepth) len = SeqDepth;
        patCount = p;
    endtask

    task automatic runMatch(input int len, input int caseNo);
        resultT      expected;
        int          waited, hold, i;
        logic [31:0] r;
        expected = predictResult(len);
        startValid = 1'b1;
        startLen = len[SeqLenW-1:0];
        waited = 0;
        while (!startReady && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        if (!startReady) begin
            errors++;
            $display("Case %0d: start request was never accepted", caseNo);
        end
        @(negedge clock);
        startValid = 1'b0;
        expectFlag("startReady", startReady, 1'b0);   // Busy now
        expectFlag("patWrReady", patWrReady, 1'b0);
        expectFlag("seqWrReady", seqWrReady, 1'b0);
        waited = 0;
        while (!resultValid && waited < 100) begin
            @(negedge clock);
            waited++;
        end
        if (!resultValid) begin
            errors++;
            $display("Case %0d: no result within 100 cycles", caseNo);
        end else begin
            if (result !== expected) begin
                errors++;
                $display("[FAIL] result: got %h expected %h in case %0d",
                         result, expected, caseNo);
            end
            r = randBits(3);
            hold = int'(r[2:0]);
            for (i = 0; i < hold; i++) begin
                startValid = 1'b1;   // Must not be taken while a result waits
                @(negedge clock);
                expectFlag("resultValid", resultValid, 1'b1);
                expectFlag("startReady", startReady, 1'b0);
                if (result !== expected) begin
                    errors++;
                    $display("[FAIL] result: got %h expected %h while held",
                             result, expected);
                end
            end
            startValid = 1'b0;
            resultReady = 1'b1;
            @(negedge clock);
            resultReady = 1'b0;
            expectFlag("resultValid", resultValid, 1'b0);
            expectFlag("startReady", startReady, 1'b1);
        end
    endtask

    initial begin
        int          i, c, patCount, len;
        logic [31:0] r;
        clock = 1'b0;
        reset_N = 1'b0;
        patWrValid = 1'b0;
        patWrAddr = '0;
        patWrOp = opLiteral;
        patWrBase = nucA;
        seqWrValid = 1'b0;
        seqWrAddr = '0;
        seqWrBase = nucA;
        startValid = 1'b0;
        startLen = '0;
        resultReady = 1'b0;
        repeat (10) @(negedge clock);
        reset_N = 1'b1;
        expectFlag("startReady", startReady, 1'b1);
        expectFlag("patWrReady", patWrReady, 1'b1);
        expectFlag("seqWrReady", seqWrReady, 1'b1);
        expectFlag("resultValid", resultValid, 1'b0);
        for (i = 0; i < PatDepth; i++) begin
            writePattern(i, opLiteral, baseT'({1'b0, i[1:0] ^ i[3:2]}));
        end
        for (c = 0; c < NumCases; c++) begin
            buildCase(patCount, len);
            for (i = 0; i < patCount; i++) writePattern(i, patOp[i], patBase[i]);
            for (i = 0; i < SeqDepth; i++) writeSequence(i, seqMem[i]);
            runMatch(len, c);
            r = randBits(2);
            if (r[1:0] == 2'd0) begin   // Rewrite one entry, rest must stay
                r = randBits(9);
                writePattern(int'(r[3:0]), opT'(r[5:4]),
                             (r[8:6] == 3'd7) ? nucOther : baseT'({1'b0, r[7:6]}));
                runMatch(len, c);
            end
        end
        $display("Match cases run: %0d, errors: %0d", NumCases, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        repeat (NumCases * 200 + 100) @(posedge clock);
        $display("Watchdog expired before the match cases finished");
        $display("Test failures found");
        $finish;
    end

endmodule : dnaMatcherTb

/* hw/dnaMatcher.sv */
module dnaMatcher (
    input  logic                        clock,
    input  logic                        reset_N,
    input  logic                        patWrValid,
    output logic                        patWrReady,
    input  logic [dnaPkg::PatAddrW-1:0] patWrAddr,
    input  dnaPkg::opT                  patWrOp,
    input  dnaPkg::baseT                patWrBase,
    input  logic                        seqWrValid,
    output logic                        seqWrReady,
    input  logic [dnaPkg::SeqAddrW-1:0] seqWrAddr,
    input  dnaPkg::baseT                seqWrBase,
    input  logic                        startValid,
    output logic                        startReady,
    input  logic [dnaPkg::SeqLenW-1:0]  startLen,
    output logic                        resultValid,
    input  logic                        resultReady,
    output dnaPkg::resultT              result
);
    import dnaPkg::*;

    logic                idle;
    logic [PatAddrW-1:0] patRdAddr;
    opT                  patRdOp;
    baseT                patRdBase;
    logic [SeqAddrW-1:0] seqRdAddr;
    baseT                seqRdBase;
    logic                memberClear;
    logic                memberLoad;
    baseT                memberBase;
    baseT                memberProbe;
    logic                memberFault;
    logic                memberHit;

    patternStore i_store (
        .clock, .reset_N, .idle,
        .patWrValid, .patWrReady, .patWrAddr, .patWrOp, .patWrBase,
        .seqWrValid, .seqWrReady, .seqWrAddr, .seqWrBase,
        .patRdAddr, .patRdOp, .patRdBase,
        .seqRdAddr, .seqRdBase
    );

    classMembers i_members (
        .clock, .reset_N,
        .memberClear, .memberLoad, .memberBase, .memberProbe,
        .memberFault, .memberHit
    );

    matchControl i_control (
        .clock, .reset_N,
        .startValid, .startReady, .startLen,
        .resultValid, .resultReady, .result, .idle,
        .patRdAddr, .patRdOp, .patRdBase, .seqRdAddr, .seqRdBase,
        .memberClear, .memberLoad, .memberBase, .memberProbe,
        .memberFault, .memberHit
    );

endmodule : dnaMatcher

/* matcher/matchControl.sv */
module matchControl (
    input  logic                        clock,
    input  logic                        reset_N,
    // Start handshake
    input  logic                        startValid,
    output logic                        startReady,
    input  logic [dnaPkg::SeqLenW-1:0]  startLen,
    // Result handshake
    output logic                        resultValid,
    input  logic                        resultReady,
    output dnaPkg::resultT              result,
    output logic                        idle,
    // Store reads
    output logic [dnaPkg::PatAddrW-1:0] patRdAddr,
    input  dnaPkg::opT                  patRdOp,
    input  dnaPkg::baseT                patRdBase,
    output logic [dnaPkg::SeqAddrW-1:0] seqRdAddr,
    input  dnaPkg::baseT                seqRdBase,
    // Member register
    output logic                        memberClear,
    output logic                        memberLoad,
    output dnaPkg::baseT                memberBase,
    output dnaPkg::baseT                memberProbe,
    input  logic                        memberFault,
    input  logic                        memberHit
);
    import dnaPkg::*;

    stateT state, nextState;

    logic [PatAddrW:0]  patIdx;    // Extra bit flags running off the end
    logic [PatAddrW:0]  patAhead;
    logic [SeqLenW-1:0] seqIdx;
    logic [SeqLenW-1:0] lenReg;
    logic [1:0]         remain;    // Class members still to collect
    resultT             resReg;
    resultT             nextRes;

    logic startFire;
    logic patStep;
    logic seqStep;
    logic loadRemain;
    logic seqExhausted;

    assign startFire    = startValid && startReady;
    assign patAhead     = patIdx + 1'b1;
    assign seqExhausted = (seqIdx == lenReg);

    assign idle        = (state == stIdle);
    assign startReady  = idle;
    assign resultValid = (state == stReport);
    assign result      = resReg;

    // Decode and collect look one entry ahead so members stream in
    assign patRdAddr = (state == stDecode || state == stCollect) ?
                       patAhead[PatAddrW-1:0] : patIdx[PatAddrW-1:0];
    assign seqRdAddr = seqIdx[SeqAddrW-1:0];

    assign memberBase  = patRdBase;
    assign memberProbe = seqRdBase;

    always_comb begin
        nextState   = state;
        nextRes     = resReg;
        patStep     = 1'b0;
        seqStep     = 1'b0;
        memberClear = 1'b0;
        memberLoad  = 1'b0;
        loadRemain  = 1'b0;
        unique case (state)
            stIdle: begin
                if (startFire) nextState = stFetch;
            end
            stFetch: begin
                if (patIdx[PatAddrW]) begin   // No end marker in pattern
                    nextRes   = resError;
                    nextState = stReport;
                end else begin
                    nextState = stDecode;
                end
            end
            stDecode: begin
                case (patRdOp)
                    opLiteral: begin
                        nextState = stReport;
                        if (!isNucleotide(patRdBase)) begin
                            nextRes = resError;
                        end else if (seqExhausted) begin
                            nextRes = resNoMatch;
                        end else if (patRdBase == seqRdBase) begin
                            patStep   = 1'b1;
                            seqStep   = 1'b1;
                            nextState = stFetch;
                        end else begin
                            nextRes = resNoMatch;
                        end
                    end
                    opClass2, opClass3: begin
                        memberClear = 1'b1;   // Header carries first member
                        memberLoad  = 1'b1;
                        loadRemain  = 1'b1;
                        patStep     = 1'b1;
                        nextState   = stCollect;
                    end
                    default: begin
                        nextRes   = (patRdBase == nucOther) ? resFound : resError;
                        nextState = stReport;
                    end
                endcase
            end
            stCollect: begin
                if (patIdx[PatAddrW] || patRdOp != opMember) begin
                    nextRes   = resError;
                    nextState = stReport;
                end else begin
                    memberLoad = 1'b1;
                    patStep    = 1'b1;
                    nextState  = (remain == 2'd1) ? stCompare : stCollect;
                end
            end
            stCompare: begin
                nextState = stReport;
                if (memberFault) begin
                    nextRes = resError;
                end else if (seqExhausted) begin
                    nextRes = resNoMatch;
                end else if (memberHit) begin
                    seqStep   = 1'b1;
                    nextState = stFetch;
                end else begin
                    nextRes = resNoMatch;
                end
            end
            stReport: begin
                if (resultReady) nextState = stIdle;   // Held until accepted
            end
            default: nextState = stIdle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            state  <= stIdle;
            patIdx <= '0;
            seqIdx <= '0;
            remain <= '0;
        end else begin
            state <= nextState;
            if (startFire) begin
                patIdx <= '0;
                seqIdx <= '0;
            end else begin
                if (patStep) patIdx <= patAhead;
                if (seqStep) seqIdx <= seqIdx + 1'b1;
            end
            if (loadRemain) begin
                remain <= (patRdOp == opClass3) ? 2'd2 : 2'd1;
            end else if (memberLoad) begin
                remain <= remain - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (startFire) lenReg <= startLen;
        resReg <= nextRes;
    end

endmodule : matchControl

/* matcher/classMembers.sv */
module classMembers (
    input  logic         clock,
    input  logic         reset_N,
    input  logic         memberClear,
    input  logic         memberLoad,
    input  dnaPkg::baseT memberBase,
    input  dnaPkg::baseT memberProbe,
    output logic         memberFault,
    output logic         memberHit
);
    import dnaPkg::*;

    logic [3:0] present;     // One flag per base A, C, T, G
    logic       badMember;   // Sticky, duplicate or non-ACGT seen
    logic [1:0] loadIdx;
    logic [1:0] probeIdx;
    logic       alreadySeen;

    assign loadIdx  = memberBase[1:0];
    assign probeIdx = memberProbe[1:0];

    // A clear in the same cycle empties the set before this load
    assign alreadySeen = present[loadIdx] && !memberClear;

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            present   <= '0;
            badMember <= 1'b0;
        end else begin
            if (memberClear) begin
                present   <= '0;
                badMember <= 1'b0;
            end
            if (memberLoad) begin
                if (!isNucleotide(memberBase) || alreadySeen) begin
                    badMember <= 1'b1;
                end else begin
                    present[loadIdx] <= 1'b1;
                end
            end
        end
    end

    assign memberFault = badMember;

    // Probe of "other" never hits
    assign memberHit = isNucleotide(memberProbe) && present[probeIdx];

endmodule : classMembers

/* matcher/patternStore.sv */
module patternStore (
    input  logic                        clock,
    input  logic                        reset_N,
    input  logic                        idle,
    // Host pattern write
    input  logic                        patWrValid,
    output logic                        patWrReady,
    input  logic [dnaPkg::PatAddrW-1:0] patWrAddr,
    input  dnaPkg::opT                  patWrOp,
    input  dnaPkg::baseT                patWrBase,
    // Host sequence write
    input  logic                        seqWrValid,
    output logic                        seqWrReady,
    input  logic [dnaPkg::SeqAddrW-1:0] seqWrAddr,
    input  dnaPkg::baseT                seqWrBase,
    // Controller reads
    input  logic [dnaPkg::PatAddrW-1:0] patRdAddr,
    output dnaPkg::opT                  patRdOp,
    output dnaPkg::baseT                patRdBase,
    input  logic [dnaPkg::SeqAddrW-1:0] seqRdAddr,
    output dnaPkg::baseT                seqRdBase
);
    import dnaPkg::*;

    opT   patOpMem   [PatDepth];
    baseT patBaseMem [PatDepth];
    baseT seqMem     [SeqDepth];

    logic patWrFire;
    logic seqWrFire;

    // Host may only write while no match is running
    assign patWrReady = idle;
    assign seqWrReady = idle;

    assign patWrFire = patWrValid && patWrReady;
    assign seqWrFire = seqWrValid && seqWrReady;

    always_ff @(posedge clock) begin
        if (patWrFire) begin
            patOpMem[patWrAddr]   <= patWrOp;
            patBaseMem[patWrAddr] <= patWrBase;
        end
        if (seqWrFire) begin
            seqMem[seqWrAddr] <= seqWrBase;
        end
    end

    // Registered read ports
    always_ff @(posedge clock) begin
        if (!reset_N) begin
            patRdOp   <= opLiteral;
            patRdBase <= nucOther;
            seqRdBase <= nucOther;
        end else begin
            patRdOp   <= patOpMem[patRdAddr];
            patRdBase <= patBaseMem[patRdAddr];
            seqRdBase <= seqMem[seqRdAddr];
        end
    end

endmodule : patternStore

/* common/dnaPkg.sv */
package dnaPkg;

    // Storage sizes
    localparam int PatDepth = 16;
    localparam int SeqDepth = 32;
    localparam int PatAddrW = 4;
    localparam int SeqAddrW = 5;
    localparam int SeqLenW  = 6;   // Holds 0 to SeqDepth

    // Nucleotide codes
    typedef enum logic [2:0] {
        nucA     = 3'd0,
        nucC     = 3'd1,
        nucT     = 3'd2,
        nucG     = 3'd3,
        nucOther = 3'd7
    } baseT;

    // Pattern entry opcodes
    typedef enum logic [1:0] {
        opLiteral = 2'd0,   // Single base
        opClass2  = 2'd1,   // Header of two-member class
        opClass3  = 2'd2,   // Header of three-member class
        opMember  = 2'd3    // Class member, or end marker as head
    } opT;

    // Match outcome
    typedef enum logic [1:0] {
        resFound   = 2'd0,
        resNoMatch = 2'd1,
        resError   = 2'd2
    } resultT;

    // Controller states
    typedef enum logic [3:0] {
        stIdle    = 4'd0,
        stFetch   = 4'd1,
        stDecode  = 4'd2,
        stCollect = 4'd3,
        stCompare = 4'd4,
        stReport  = 4'd5
    } stateT;

    // Only A, C, T and G count as real bases
    function automatic logic isNucleotide(baseT b);
        logic ok;
        ok = (b == nucA) || (b == nucC) || (b == nucT) || (b == nucG);
        return ok;
    endfunction

endpackage : dnaPkg
